// File: test/issue_input.txt
# hex fields: disp fu op rd rs1 rs2 imm imm_sel t1 t2 | wb reg data | done fu | exp fu rd rdat1 rdat2
# drain waits for all expected issues | flush | halt | halt_is v | idle n
wb 3 00000011
wb 4 00000022
# operand read, then immediate with r0
disp 0 0 05 03 04 0000 0 0 0
exp 0 05 00000011 00000022
drain
done 0
disp 0 3 06 00 04 007f 1 0 0
exp 0 06 00000000 0000007f
drain
done 0
# load waits on the ALU
disp 0 0 07 03 03 0000 0 0 0
exp 0 07 00000011 00000011
drain
disp 1 4 08 04 00 0010 1 1 0
idle 5
exp 1 08 00000022 00000010
done 0
drain
done 1
# GEMM, branch and matrix rows behind one ALU op
disp 0 1 0c 04 03 0000 0 0 0
exp 0 0c 00000022 00000011
drain
disp 4 8 09 03 04 0000 0 1 0
disp 2 6 00 03 03 0000 0 0 1
disp 3 7 0a 04 00 0020 1 1 0
exp 4 09 00000011 00000022
exp 2 00 00000011 00000011
exp 3 0a 00000022 00000020
done 0
drain
done 4
done 2
done 3
# flush with ALU, load and GEMM rows occupied
disp 0 2 0d 03 04 0000 0 0 0
exp 0 0d 00000011 00000022
drain
disp 1 5 00 04 03 0000 0 1 0
disp 4 8 0e 03 03 0000 0 0 1
flush
idle 6
# halt waits for the last row
disp 0 0 0f 03 04 0000 0 0 0
exp 0 0f 00000011 00000022
drain
disp 1 4 10 03 00 0004 1 1 0
halt
halt_is 0
idle 2
halt_is 0
exp 1 10 00000011 00000004
done 0
drain
halt_is 0
done 1
halt_is 1
idle 3
halt_is 1

// File: sources.f
rtl/issue_pkg.sv
rtl/fust_if.sv
rtl/fust_table.sv
rtl/fust_fsm.sv
rtl/age_tracker.sv
rtl/issue_select.sv
rtl/regfile.sv
rtl/issue_stage.sv
test/issue_stage_checker.sv
test/issue_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the issue stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module issue_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vissue_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "no result found in $LOG"
    exit 1
fi
exit 0

// File: test/issue_stage_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module issue_stage_tb;

    localparam int DATA_W     = 32;
    localparam int WAIT_LIMIT = 60;

    // one expected issue record
    typedef struct packed {
        logic [issue_pkg::FU_W-1:0]  fu;
        logic [issue_pkg::OP_W-1:0]  op;
        logic [issue_pkg::REG_W-1:0] rd;
        logic [DATA_W-1:0]           d1;
        logic [DATA_W-1:0]           d2;
    } exp_rec_t;

    logic                         CLK;
    logic                         nRST;
    logic                         disp_valid;
    issue_pkg::fu_e               disp_fu;
    issue_pkg::op_e               disp_op;
    logic [issue_pkg::REG_W-1:0]  disp_rd, disp_rs1, disp_rs2;
    logic [issue_pkg::IMM_W-1:0]  disp_imm;
    logic                         disp_imm_sel;
    logic [issue_pkg::TAG_W-1:0]  disp_t1, disp_t2;
    logic [issue_pkg::NUM_FU-1:0] credit_return;
    logic [issue_pkg::NUM_FU-1:0] fu_done;
    logic                         wb_en;
    logic [issue_pkg::REG_W-1:0]  wb_sel;
    logic [DATA_W-1:0]            wb_data;
    logic                         branch_miss;
    logic                         halt_req;
    logic                         iss_valid;
    issue_pkg::fu_e               iss_fu;
    issue_pkg::op_e               iss_op;
    logic [issue_pkg::REG_W-1:0]  iss_rd;
    logic [DATA_W-1:0]            iss_rdat1, iss_rdat2;
    logic                         halt;

    // dispatcher model
    int                           credits [issue_pkg::NUM_FU];
    int                           sent_op [issue_pkg::NUM_FU];
    logic [issue_pkg::NUM_FU-1:0] occupied;
    exp_rec_t                     exp_q [$];
    int                           errors;
    int                           checks;
    bit                           aborted;

    issue_stage #(.DATA_W(DATA_W), .AGE_W(3)) issue_stage_inst (.*);

    initial begin : clock_gen
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic wait_credit(input int fu);
        int n;
        n = 0;
        while (credits[fu] == 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (credits[fu] == 0) begin
            $display("timeout waiting for a credit of unit %0d", fu);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic dispatch(input int fu, input int op, input int rd, input int rs1,
                            input int rs2, input int imm, input int isel,
                            input int t1, input int t2);
        wait_credit(fu);
        if (!aborted) begin
            disp_valid   = 1'b1;
            disp_fu      = issue_pkg::fu_e'(fu);
            disp_op      = issue_pkg::op_e'(op);
            disp_rd      = issue_pkg::REG_W'(rd);
            disp_rs1     = issue_pkg::REG_W'(rs1);
            disp_rs2     = issue_pkg::REG_W'(rs2);
            disp_imm     = issue_pkg::IMM_W'(imm);
            disp_imm_sel = isel[0];
            disp_t1      = issue_pkg::TAG_W'(t1);
            disp_t2      = issue_pkg::TAG_W'(t2);
            // sending spends the unit's only credit
            credits[fu]--;
            occupied[fu] = 1'b1;
            sent_op[fu]  = op;
            next_cycle();
            disp_valid = 1'b0;
        end
    endtask

    task automatic write_back(input int sel, input logic [31:0] data);
        wb_en   = 1'b1;
        wb_sel  = issue_pkg::REG_W'(sel);
        wb_data = data;
        next_cycle();
        wb_en = 1'b0;
    endtask

    // credit comes back one cycle after done
    task automatic finish_unit(input int fu);
        fu_done[fu] = 1'b1;
        next_cycle();
        fu_done = '0;
        compare_value($sformatf("credit_return[%0d]", fu), 32'(credit_return[fu]), 32'd1);
        occupied[fu] = 1'b0;
    endtask

    // every occupied row gives its credit back
    task automatic flush_rows();
        logic [issue_pkg::NUM_FU-1:0] mask;
        mask        = occupied;
        branch_miss = 1'b1;
        next_cycle();
        branch_miss = 1'b0;
        compare_value("credit_return", 32'(credit_return), 32'(mask));
        occupied = '0;
    endtask

    task automatic drain_issues();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout, %0d expected issues never arrived", exp_q.size());
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_command(input string line);
        string       cmd;
        int          n;
        int          cycles;
        int          fu, op, rd, rs1, rs2, imm, isel, t1, t2;
        logic [31:0] d1, d2;
        exp_rec_t    rec;
        n = $sscanf(line, "%s", cmd);
        if (cmd == "disp") begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                        cmd, fu, op, rd, rs1, rs2, imm, isel, t1, t2);
            dispatch(fu, op, rd, rs1, rs2, imm, isel, t1, t2);
        end else if (cmd == "wb") begin
            n = $sscanf(line, "%s %h %h", cmd, rd, d1);
            write_back(rd, d1);
        end else if (cmd == "done") begin
            n = $sscanf(line, "%s %h", cmd, fu);
            finish_unit(fu);
        end else if (cmd == "exp") begin
            n = $sscanf(line, "%s %h %h %h %h", cmd, fu, rd, d1, d2);
            rec.fu = issue_pkg::FU_W'(fu);
            // the packet carries the opcode that was dispatched to that unit
            rec.op = issue_pkg::OP_W'(sent_op[fu]);
            rec.rd = issue_pkg::REG_W'(rd);
            rec.d1 = d1;
            rec.d2 = d2;
            exp_q.push_back(rec);
        end else if (cmd == "idle") begin
            n = $sscanf(line, "%s %h", cmd, cycles);
            repeat (cycles) next_cycle();
        end else if (cmd == "halt_is") begin
            n = $sscanf(line, "%s %h", cmd, d1);
            compare_value("halt", 32'(halt), d1);
        end else if (cmd == "halt") begin
            halt_req = 1'b1;
            next_cycle();
            halt_req = 1'b0;
        end else if (cmd == "flush") begin
            flush_rows();
        end else if (cmd == "drain") begin
            drain_issues();
        end else begin
            $display("unknown command in stimulus file: %s", cmd);
            errors++;
        end
    endtask

    // issue and credit monitor sampled mid-cycle
    always @(negedge CLK) begin : issue_monitor
        exp_rec_t rec;
        if (nRST) begin
            for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
                if (credit_return[k]) begin
                    credits[k]++;
                    if (credits[k] > 1) begin
                        $display("unit %0d returned a credit it never spent", k);
                        errors++;
                    end
                end
            end
            if (iss_valid && exp_q.size() == 0) begin
                $display("unit %0d issued with no issue expected at %0t ns", iss_fu, $time);
                errors++;
            end else if (iss_valid) begin
                rec = exp_q.pop_front();
                compare_value("iss_fu", 32'(iss_fu), 32'(rec.fu));
                compare_value("iss_op", 32'(iss_op), 32'(rec.op));
                compare_value("iss_rd", 32'(iss_rd), 32'(rec.rd));
                compare_value("iss_rdat1", iss_rdat1, rec.d1);
                compare_value("iss_rdat2", iss_rdat2, rec.d2);
            end
        end
    end

    initial begin : main
        int    fd;
        int    code;
        string line;
        nRST         = 1'b0;
        disp_valid   = 1'b0;
        disp_fu      = issue_pkg::FU_ALU;
        disp_op      = issue_pkg::OP_ADD;
        disp_rd      = '0;
        disp_rs1     = '0;
        disp_rs2     = '0;
        disp_imm     = '0;
        disp_imm_sel = 1'b0;
        disp_t1      = '0;
        disp_t2      = '0;
        fu_done      = '0;
        wb_en        = 1'b0;
        wb_sel       = '0;
        wb_data      = '0;
        branch_miss  = 1'b0;
        halt_req     = 1'b0;
        errors       = 0;
        checks       = 0;
        aborted      = 1'b0;
        occupied     = '0;
        // one credit per unit after reset
        for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
            credits[k] = 1;
            sent_op[k] = 0;
        end
        fd = $fopen("test/issue_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file test/issue_input.txt");
            errors++;
            aborted = 1'b1;
        end
        repeat (8) @(posedge CLK);
        #1 nRST = 1'b1;
        while (!aborted && !$feof(fd)) begin
            code = $fgets(line, fd);
            // blank lines and # comments are skipped
            if (code != 0 && line.len() > 1 && line[0] != "#")
                run_command(line);
        end
        if (fd != 0)
            $fclose(fd);
        if (!aborted) begin
            repeat (4) next_cycle();
            compare_value("pending issues", 32'(exp_q.size()), 32'd0);
            for (int k = 0; k < issue_pkg::NUM_FU; k++)
                compare_value($sformatf("credits[%0d]", k), 32'(credits[k]), 32'd1);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: test/issue_stage_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module issue_stage_checker (
    input logic                         CLK,
    input logic                         nRST,
    input logic                         iss_valid,
    input logic [issue_pkg::FU_W-1:0]   iss_fu,
    input logic [issue_pkg::NUM_FU-1:0] credit_return,
    input logic                         halt
);

    // units issued and not yet given back
    logic [issue_pkg::NUM_FU-1:0] in_flight;

    always_ff @(posedge CLK, negedge nRST) begin : flight_track
        if (!nRST) begin
            in_flight <= '0;
        end else begin
            for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
                if (credit_return[k])
                    in_flight[k] <= 1'b0;
                else if (iss_valid && int'(iss_fu) == k)
                    in_flight[k] <= 1'b1;
            end
        end
    end

    // a second issue needs the row to have emptied first
    reissue_after_credit: assert property (@(posedge CLK) disable iff (!nRST)
        iss_valid |-> !in_flight[iss_fu])
        else $error("unit issued twice without a credit return");

    no_credit_in_reset: assert property (@(posedge CLK)
        !nRST |-> credit_return == '0)
        else $error("credit_return active during reset");

    // drained and halted, nothing may leave the stage
    quiet_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
        halt |=> !iss_valid)
        else $error("issue after halt");

endmodule

bind issue_stage issue_stage_checker issue_stage_checker_inst (
    .CLK, .nRST, .iss_valid, .iss_fu, .credit_return, .halt
);

// File: rtl/issue_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module issue_stage #(
    parameter int DATA_W = 32,
    parameter int AGE_W  = 3
) (
    input  logic                         CLK,
    input  logic                         nRST,
    // dispatch side
    input  logic                         disp_valid,
    input  issue_pkg::fu_e               disp_fu,
    input  issue_pkg::op_e               disp_op,
    input  logic [issue_pkg::REG_W-1:0]  disp_rd,
    input  logic [issue_pkg::REG_W-1:0]  disp_rs1,
    input  logic [issue_pkg::REG_W-1:0]  disp_rs2,
    input  logic [issue_pkg::IMM_W-1:0]  disp_imm,
    input  logic                         disp_imm_sel,
    input  logic [issue_pkg::TAG_W-1:0]  disp_t1,
    input  logic [issue_pkg::TAG_W-1:0]  disp_t2,
    output logic [issue_pkg::NUM_FU-1:0] credit_return,
    // completion and write-back
    input  logic [issue_pkg::NUM_FU-1:0] fu_done,
    input  logic                         wb_en,
    input  logic [issue_pkg::REG_W-1:0]  wb_sel,
    input  logic [DATA_W-1:0]            wb_data,
    input  logic                         branch_miss,
    input  logic                         halt_req,
    // issue side
    output logic                         iss_valid,
    output issue_pkg::fu_e               iss_fu,
    output issue_pkg::op_e               iss_op,
    output logic [issue_pkg::REG_W-1:0]  iss_rd,
    output logic [DATA_W-1:0]            iss_rdat1,
    output logic [DATA_W-1:0]            iss_rdat2,
    output logic                         halt
);

    logic [issue_pkg::REG_W-1:0] rsel1, rsel2;
    logic [DATA_W-1:0]           rdat1, rdat2;
    logic                        disp_ok;
    logic                        halt_q;
    logic                        all_empty;

    fust_if #(.AGE_W(AGE_W)) fu_if ();

    // flush wins over a dispatch in the same cycle
    assign disp_ok = disp_valid && !branch_miss;

    fust_table fust_table_inst (
        .CLK, .nRST, .disp_valid, .disp_fu, .disp_op, .disp_rd, .disp_rs1, .disp_rs2,
        .disp_imm, .disp_imm_sel, .disp_t1, .disp_t2, .fu_done, .branch_miss,
        .fu_if(fu_if.tbl)
    );

    fust_fsm #(.AGE_W(AGE_W)) fust_fsm_inst (
        .CLK, .nRST, .disp_valid, .disp_fu, .fu_done, .branch_miss, .credit_return,
        .fu_if(fu_if.fsm)
    );

    age_tracker #(.AGE_W(AGE_W)) age_tracker_inst (
        .CLK, .nRST, .disp_valid(disp_ok), .disp_fu, .fu_if(fu_if.ages)
    );

    issue_select #(.DATA_W(DATA_W)) issue_select_inst (
        .CLK, .nRST, .fu_if(fu_if.select), .rsel1, .rsel2, .rdat1, .rdat2,
        .iss_valid, .iss_fu, .iss_op, .iss_rd, .iss_rdat1, .iss_rdat2
    );

    regfile #(.DATA_W(DATA_W)) regfile_inst (
        .CLK, .nRST, .wb_en, .wb_sel, .wb_data, .rsel1, .rsel2, .rdat1, .rdat2
    );

    // sticky halt request
    always_ff @(posedge CLK, negedge nRST) begin : halt_latch
        if (!nRST)
            halt_q <= 1'b0;
        else
            halt_q <= halt_q || halt_req;
    end

    always_comb begin : drain_check
        all_empty = 1'b1;
        for (int i = 0; i < issue_pkg::NUM_FU; i++)
            if (fu_if.state[i] != issue_pkg::FUST_EMPTY)
                all_empty = 1'b0;
    end

    // halt only once every row has drained
    assign halt = halt_q && all_empty;

endmodule

// File: rtl/regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module regfile #(
    parameter int DATA_W = 32
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        wb_en,
    input  logic [issue_pkg::REG_W-1:0] wb_sel,
    input  logic [DATA_W-1:0]           wb_data,
    input  logic [issue_pkg::REG_W-1:0] rsel1,
    input  logic [issue_pkg::REG_W-1:0] rsel2,
    output logic [DATA_W-1:0]           rdat1,
    output logic [DATA_W-1:0]           rdat2
);

    logic [DATA_W-1:0] regs [2**issue_pkg::REG_W];

    // r0 is hardwired, a matching write is forwarded to the reader
    function automatic logic [DATA_W-1:0] read_port(input logic [issue_pkg::REG_W-1:0] sel);
        if (sel == '0)
            return '0;
        if (wb_en && wb_sel == sel)
            return wb_data;
        return regs[sel];
    endfunction

    always_ff @(posedge CLK, negedge nRST) begin : reg_write
        if (!nRST) begin
            for (int i = 0; i < 2**issue_pkg::REG_W; i++)
                regs[i] <= '0;
        end else if (wb_en && wb_sel != '0) begin
            regs[wb_sel] <= wb_data;
        end
    end

    always_comb rdat1 = read_port(rsel1);
    always_comb rdat2 = read_port(rsel2);

endmodule

// File: rtl/issue_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue packet register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module issue_select #(
    parameter int DATA_W = 32
) (
    input  logic                        CLK,
    input  logic                        nRST,
    fust_if.select                      fu_if,
    output logic [issue_pkg::REG_W-1:0] rsel1,
    output logic [issue_pkg::REG_W-1:0] rsel2,
    input  logic [DATA_W-1:0]           rdat1,
    input  logic [DATA_W-1:0]           rdat2,
    output logic                        iss_valid,
    output issue_pkg::fu_e              iss_fu,
    output issue_pkg::op_e              iss_op,
    output logic [issue_pkg::REG_W-1:0] iss_rd,
    output logic [DATA_W-1:0]           iss_rdat1,
    output logic [DATA_W-1:0]           iss_rdat2
);

    logic                       issue_any;
    logic [issue_pkg::IMM_W-1:0] imm;
    logic [DATA_W-1:0]          imm_ext;
    logic [DATA_W-1:0]          operand2;

    assign issue_any = |fu_if.issue_row;

    // source registers of the chosen row go straight to the read ports
    assign rsel1 = fu_if.rs1[fu_if.issue_fu];
    assign rsel2 = fu_if.rs2[fu_if.issue_fu];

    // immediate is sign extended to a full word
    assign imm      = fu_if.imm[fu_if.issue_fu];
    assign imm_ext  = {{(DATA_W - issue_pkg::IMM_W){imm[issue_pkg::IMM_W-1]}}, imm};
    assign operand2 = fu_if.imm_sel[fu_if.issue_fu] ? imm_ext : rdat2;

    always_ff @(posedge CLK, negedge nRST) begin : valid_reg
        if (!nRST)
            iss_valid <= 1'b0;
        else
            iss_valid <= issue_any;
    end

    // payload only loads when a row is picked
    always_ff @(posedge CLK) begin : packet_reg
        if (issue_any) begin
            iss_fu    <= fu_if.issue_fu;
            iss_op    <= fu_if.op[fu_if.issue_fu];
            iss_rd    <= fu_if.rd[fu_if.issue_fu];
            iss_rdat1 <= rdat1;
            iss_rdat2 <= operand2;
        end
    end

endmodule

// File: rtl/age_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// row age counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module age_tracker #(
    parameter int AGE_W = 3
) (
    input  logic           CLK,
    input  logic           nRST,
    input  logic           disp_valid,
    input  issue_pkg::fu_e disp_fu,
    fust_if.ages           fu_if
);

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    logic [issue_pkg::NUM_FU-1:0][AGE_W-1:0] age_q, age_n;

    always_comb begin : age_next
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            case (fu_if.state[i])
                // fresh entry starts at 1
                issue_pkg::FUST_EMPTY:
                    age_n[i] = (disp_valid && int'(disp_fu) == i) ? AGE_W'(1) : '0;
                // waiting rows grow older with every newer dispatch, saturating
                issue_pkg::FUST_WAIT, issue_pkg::FUST_RDY:
                    age_n[i] = (disp_valid && age_q[i] != AGE_MAX) ?
                               age_q[i] + AGE_W'(1) : age_q[i];
                default:
                    age_n[i] = '0;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin : age_reg
        if (!nRST)
            age_q <= '0;
        else
            age_q <= age_n;
    end

    // only waiting rows show an age, so a flushed row reads 0 right away
    always_comb begin : age_out
        for (int i = 0; i < issue_pkg::NUM_FU; i++)
            fu_if.age[i] = (fu_if.state[i] == issue_pkg::FUST_WAIT ||
                            fu_if.state[i] == issue_pkg::FUST_RDY) ? age_q[i] : '0;
    end

endmodule

// File: rtl/fust_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// row state machine and issue policy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fust_fsm #(
    parameter int AGE_W = 3
) (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         disp_valid,
    input  issue_pkg::fu_e               disp_fu,
    input  logic [issue_pkg::NUM_FU-1:0] fu_done,
    input  logic                         branch_miss,
    output logic [issue_pkg::NUM_FU-1:0] credit_return,
    fust_if.fsm                          fu_if
);

    issue_pkg::fust_state_e [issue_pkg::NUM_FU-1:0] state_n;

    // oldest ready row wins, strict compare keeps the lowest index on a tie
    always_comb begin : oldest_ready
        logic                       found;
        logic [AGE_W-1:0]           best_age;
        logic [issue_pkg::FU_W-1:0] best;
        found    = 1'b0;
        best_age = '0;
        best     = '0;
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            if (fu_if.state[i] == issue_pkg::FUST_RDY && (!found || fu_if.age[i] > best_age)) begin
                found    = 1'b1;
                best_age = fu_if.age[i];
                best     = issue_pkg::FU_W'(i);
            end
        end
        fu_if.issue_row = '0;
        fu_if.issue_fu  = issue_pkg::fu_e'(best);
        // nothing issues out of a row that is being flushed
        if (found && !branch_miss)
            fu_if.issue_row[best] = 1'b1;
    end

    always_comb begin : next_state
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            state_n[i] = fu_if.state[i];
            if (branch_miss)
                state_n[i] = issue_pkg::FUST_EMPTY;
            else begin
                case (fu_if.state[i])
                    issue_pkg::FUST_EMPTY:
                        if (disp_valid && int'(disp_fu) == i)
                            state_n[i] = issue_pkg::FUST_WAIT;
                    issue_pkg::FUST_WAIT:
                        if (fu_if.tags_clear[i])
                            state_n[i] = issue_pkg::FUST_RDY;
                    issue_pkg::FUST_RDY:
                        if (fu_if.issue_row[i])
                            state_n[i] = issue_pkg::FUST_EX;
                    default:
                        // EX holds the row and its credit until the unit finishes
                        if (fu_done[i])
                            state_n[i] = issue_pkg::FUST_EMPTY;
                endcase
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin : state_reg
        if (!nRST) begin
            fu_if.state   <= {issue_pkg::NUM_FU{issue_pkg::FUST_EMPTY}};
            credit_return <= '0;
        end else begin
            fu_if.state <= state_n;
            // one credit per occupied row that empties
            for (int i = 0; i < issue_pkg::NUM_FU; i++)
                credit_return[i] <= (fu_if.state[i] != issue_pkg::FUST_EMPTY) &&
                                    (state_n[i] == issue_pkg::FUST_EMPTY);
        end
    end

endmodule

// File: rtl/fust_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// status table rows
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fust_table (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    disp_valid,
    input  issue_pkg::fu_e                          disp_fu,
    input  issue_pkg::op_e                          disp_op,
    input  logic [issue_pkg::REG_W-1:0]             disp_rd,
    input  logic [issue_pkg::REG_W-1:0]             disp_rs1,
    input  logic [issue_pkg::REG_W-1:0]             disp_rs2,
    input  logic [issue_pkg::IMM_W-1:0]             disp_imm,
    input  logic                                    disp_imm_sel,
    input  logic [issue_pkg::TAG_W-1:0]             disp_t1,
    input  logic [issue_pkg::TAG_W-1:0]             disp_t2,
    input  logic [issue_pkg::NUM_FU-1:0]            fu_done,
    input  logic                                    branch_miss,
    fust_if.tbl                                     fu_if
);

    logic [issue_pkg::NUM_FU-1:0][issue_pkg::TAG_W-1:0] t1, t2;

    // drop a tag whose producer finishes this cycle
    function automatic logic [issue_pkg::TAG_W-1:0] clear_done(
        input logic [issue_pkg::TAG_W-1:0]  tag,
        input logic [issue_pkg::NUM_FU-1:0] done
    );
        logic [issue_pkg::TAG_W-1:0] res;
        res = tag;
        for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
            if (done[k] && tag == issue_pkg::TAG_W'(k + 1))
                res = '0;
        end
        return res;
    endfunction

    // instruction fields, a dispatch during a flush is dropped
    always_ff @(posedge CLK) begin : row_write
        if (disp_valid && !branch_miss) begin
            fu_if.op[disp_fu]      <= disp_op;
            fu_if.rd[disp_fu]      <= disp_rd;
            fu_if.rs1[disp_fu]     <= disp_rs1;
            fu_if.rs2[disp_fu]     <= disp_rs2;
            fu_if.imm[disp_fu]     <= disp_imm;
            fu_if.imm_sel[disp_fu] <= disp_imm_sel;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin : tag_update
        if (!nRST) begin
            t1 <= '0;
            t2 <= '0;
        end else if (branch_miss) begin
            t1 <= '0;
            t2 <= '0;
        end else begin
            for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
                t1[i] <= clear_done(t1[i], fu_done);
                t2[i] <= clear_done(t2[i], fu_done);
            end
            // incoming tags see the same done pulses, else they would never clear
            if (disp_valid) begin
                t1[disp_fu] <= clear_done(disp_t1, fu_done);
                t2[disp_fu] <= clear_done(disp_t2, fu_done);
            end
        end
    end

    always_comb begin : ready_bits
        for (int i = 0; i < issue_pkg::NUM_FU; i++)
            fu_if.tags_clear[i] = (t1[i] == '0) && (t2[i] == '0);
    end

endmodule

// File: rtl/fust_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// status table interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface fust_if #(parameter int AGE_W = 3);

    // per-row control
    issue_pkg::fust_state_e [issue_pkg::NUM_FU-1:0] state;
    logic [issue_pkg::NUM_FU-1:0]                   tags_clear;
    logic [issue_pkg::NUM_FU-1:0][AGE_W-1:0]        age;

    // chosen row, one-hot plus its unit code
    logic [issue_pkg::NUM_FU-1:0] issue_row;
    issue_pkg::fu_e               issue_fu;

    // row contents
    issue_pkg::op_e [issue_pkg::NUM_FU-1:0]                 op;
    logic [issue_pkg::NUM_FU-1:0][issue_pkg::REG_W-1:0]     rd, rs1, rs2;
    logic [issue_pkg::NUM_FU-1:0][issue_pkg::IMM_W-1:0]     imm;
    logic [issue_pkg::NUM_FU-1:0]                           imm_sel;

    modport tbl    (output tags_clear, op, rd, rs1, rs2, imm, imm_sel);
    modport fsm    (input tags_clear, age, output state, issue_row, issue_fu);
    modport ages   (input state, output age);
    modport select (input issue_row, issue_fu, op, rd, rs1, rs2, imm, imm_sel);

endinterface

// File: rtl/issue_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package issue_pkg;

    // one table row per functional unit
    localparam int NUM_FU = 5;

    // register index width, 32 architectural registers
    localparam int REG_W  = 5;

    // dependency tag: 0 is no dependency, k+1 waits on unit k
    localparam int TAG_W  = 3;

    // issue packet field widths
    localparam int FU_W   = 3;
    localparam int ST_W   = 2;
    localparam int OP_W   = 4;
    localparam int IMM_W  = 16;

    // unit encoding matches the row index
    typedef enum logic [FU_W-1:0] {
        FU_ALU    = 3'd0,
        FU_LDST   = 3'd1,
        FU_BRANCH = 3'd2,
        FU_MLS    = 3'd3,
        FU_GEMM   = 3'd4
    } fu_e;

    // row life cycle
    typedef enum logic [ST_W-1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_LD   = 4'd4,
        OP_ST   = 4'd5,
        OP_BEQ  = 4'd6,
        OP_MLD  = 4'd7,
        OP_GEMM = 4'd8
    } op_e;

endpackage
